// File: Makefile
# Verilator flow for the pipelined ALU
# Override any variable on the command line, e.g. make sim SEED=32'h12345678

VERILATOR ?= verilator
TOP       ?= alu_core_tb
RTL_TOP   ?= alu_core
SEED      ?= 32'he328b0a9
LOG       ?= sim.log
FILELIST  ?= alu_core.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) \
		"-GSEED=$(SEED)" -f $(FILELIST)

sim: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "RESULT: PASS" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: alu_core.f
+incdir+hw
hw/alu_pkg.sv
hw/delay_line.sv
hw/addsub_unit.sv
hw/bitwise_unit.sv
hw/mult_unit.sv
hw/alu_core.sv
tb/alu_core_tb.sv

// File: hw/addsub_unit.sv
`timescale 1ns/1ps

module addsub_unit (
    input  logic               clock,
    input  logic               rst,
    input  logic               subtract,
    input  logic               carry_in,
    input  alu_pkg::alu_word_t a,
    input  alu_pkg::alu_word_t b,
    output alu_pkg::alu_word_t sum,
    output logic               carry_out
);

    localparam int W  = $bits(alu_pkg::alu_word_t);
    localparam int LO = W / 2;
    localparam int HI = W - LO;

    alu_pkg::alu_word_t b_eff;
    logic [LO:0]        lo_sum;
    logic [HI:0]        hi_sum;

    // Stage 1 registers
    logic [LO-1:0]      lo_q;
    logic               carry_q;
    logic [HI-1:0]      a_hi_q;
    logic [HI-1:0]      b_hi_q;

    always_comb begin
        // Subtraction is a + ~b + carry_in
        b_eff  = subtract ? ~b : b;
        lo_sum = {1'b0, a[LO-1:0]} + {1'b0, b_eff[LO-1:0]} + {{LO{1'b0}}, carry_in};
        // Upper half works on the operands held by stage 1
        hi_sum = {1'b0, a_hi_q} + {1'b0, b_hi_q} + {{HI{1'b0}}, carry_q};
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            lo_q      <= '0;
            carry_q   <= 1'b0;
            a_hi_q    <= '0;
            b_hi_q    <= '0;
            sum       <= '0;
            carry_out <= 1'b0;
        end else begin
            lo_q      <= lo_sum[LO-1:0];
            carry_q   <= lo_sum[LO];
            a_hi_q    <= a[W-1:LO];
            b_hi_q    <= b_eff[W-1:LO];
            sum       <= {hi_sum[HI-1:0], lo_q};
            carry_out <= hi_sum[HI];
        end
    end

endmodule

// File: hw/alu_core.sv
`timescale 1ns/1ps
`include "alu_defs.svh"

module alu_core (
    input  logic              clock,
    input  logic              rst,
    input  alu_pkg::alu_req_t req,
    input  alu_pkg::alu_tag_t tag_in,
    output alu_pkg::alu_rsp_t rsp
);

    localparam int LAT = `ALU_LATENCY;

    // Registered request history, req_q[i] is the request from i+1 cycles ago
    alu_pkg::alu_req_t  req_q [LAT-1];
    // Tap k sees the request k cycles after it arrived, tap 0 is req itself
    alu_pkg::alu_req_t  tap   [LAT];

    alu_pkg::alu_req_t  add_req;
    alu_pkg::alu_req_t  bit_req;
    alu_pkg::alu_req_t  out_req;

    logic               subtract;
    logic               is_signed;
    alu_pkg::alu_word_t add_sum;
    logic               add_carry;
    logic               carry_aligned;
    alu_pkg::alu_word_t bit_result;
    alu_pkg::alu_word_t prod_lo;
    alu_pkg::alu_word_t prod_hi;
    alu_pkg::alu_tag_t  tag_q;

    // Final output registers
    alu_pkg::alu_op_e   op_q;
    alu_pkg::alu_word_t result_q;
    logic               carry_q;

    // Reset fills the history with op_nop
    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < LAT - 1; i++) begin
                req_q[i] <= '0;
            end
        end else begin
            req_q[0] <= req;
            for (int i = 1; i < LAT - 1; i++) begin
                req_q[i] <= req_q[i-1];
            end
        end
    end

    always_comb begin
        tap[0] = req;
        for (int k = 1; k < LAT; k++) begin
            tap[k] = req_q[k-1];
        end
    end

    // Adder finishes just as its request reaches the bitwise tap
    assign add_req   = tap[LAT-4];
    assign bit_req   = tap[LAT-2];
    assign out_req   = tap[LAT-1];

    assign subtract  = (add_req.op == alu_pkg::op_sub);
    assign is_signed = (req.op == alu_pkg::op_muls_lo) || (req.op == alu_pkg::op_muls_hi);

    addsub_unit u_addsub (
        .clock     (clock),
        .rst       (rst),
        .subtract  (subtract),
        .carry_in  (add_req.carry_in),
        .a         (add_req.a),
        .b         (add_req.b),
        .sum       (add_sum),
        .carry_out (add_carry)
    );

    // Carry skips the bitwise stage, so hold it one cycle
    delay_line #(
        .DEPTH (1),
        .WIDTH (1)
    ) u_carry_dly (
        .clock (clock),
        .rst   (rst),
        .din   (add_carry),
        .dout  (carry_aligned)
    );

    bitwise_unit u_bitwise (
        .clock         (clock),
        .rst           (rst),
        .op            (bit_req.op),
        .a             (bit_req.a),
        .b             (bit_req.b),
        .addsub_result (add_sum),
        .result        (bit_result)
    );

    // Deepest unit, fed straight from the input
    mult_unit #(
        .STAGES (`ALU_MULT_STAGES)
    ) u_mult (
        .clock      (clock),
        .rst        (rst),
        .is_signed  (is_signed),
        .a          (req.a),
        .b          (req.b),
        .product_lo (prod_lo),
        .product_hi (prod_hi)
    );

    delay_line #(
        .DEPTH (LAT),
        .WIDTH ($bits(alu_pkg::alu_tag_t))
    ) u_tag_dly (
        .clock (clock),
        .rst   (rst),
        .din   (tag_in),
        .dout  (tag_q)
    );

    always_ff @(posedge clock) begin
        if (rst) begin
            op_q     <= alu_pkg::op_nop;
            result_q <= '0;
            carry_q  <= 1'b0;
        end else begin
            op_q <= out_req.op;
            case (out_req.op)
                alu_pkg::op_mulu_lo, alu_pkg::op_muls_lo: begin
                    result_q <= prod_lo;
                end
                alu_pkg::op_mulu_hi, alu_pkg::op_muls_hi: begin
                    result_q <= prod_hi;
                end
                default: begin
                    result_q <= bit_result;
                end
            endcase
            // Carry only means something for add and sub
            carry_q <= ((out_req.op == alu_pkg::op_add) || (out_req.op == alu_pkg::op_sub))
                       ? carry_aligned : 1'b0;
        end
    end

    always_comb begin
        rsp.op        = op_q;
        rsp.result    = result_q;
        rsp.carry_out = carry_q;
        rsp.tag       = tag_q;
    end

endmodule

// File: hw/alu_defs.svh
`ifndef ALU_DEFS_SVH
`define ALU_DEFS_SVH

// Operand and result width in bits
`define ALU_WORD_WIDTH 16

// Destination tag width, carried unchanged to the response
`define ALU_TAG_WIDTH 8

// Opcode encoding width
`define ALU_OP_WIDTH 4

// Register stages inside the multiplier, at least 3
`define ALU_MULT_STAGES 3

// Cycles from input to registered output
// The multiplier is the deepest unit, the final selector adds one
`define ALU_LATENCY (`ALU_MULT_STAGES + 1)

`endif

// File: hw/alu_pkg.sv
`include "alu_defs.svh"

package alu_pkg;

    // Operand, result and product words
    typedef logic [`ALU_WORD_WIDTH-1:0]   alu_word_t;
    typedef logic [2*`ALU_WORD_WIDTH-1:0] alu_dword_t;

    // Destination tag, opaque to the ALU
    typedef logic [`ALU_TAG_WIDTH-1:0] alu_tag_t;

    // op_nop must stay at zero, reset flushes the pipeline with it
    typedef enum logic [`ALU_OP_WIDTH-1:0] {
        op_nop     = 4'd0,
        op_add     = 4'd1,
        op_sub     = 4'd2,
        op_and     = 4'd3,
        op_or      = 4'd4,
        op_xor     = 4'd5,
        op_mulu_lo = 4'd6,
        op_mulu_hi = 4'd7,
        op_muls_lo = 4'd8,
        op_muls_hi = 4'd9
    } alu_op_e;

    // One operation as it enters and travels down the pipeline
    typedef struct packed {
        alu_op_e   op;
        alu_word_t a;
        alu_word_t b;
        logic      carry_in;
    } alu_req_t;

    // Registered result bundle
    typedef struct packed {
        alu_op_e   op;
        alu_word_t result;
        logic      carry_out;
        alu_tag_t  tag;
    } alu_rsp_t;

endpackage

// File: hw/bitwise_unit.sv
`timescale 1ns/1ps

module bitwise_unit (
    input  logic               clock,
    input  logic               rst,
    input  alu_pkg::alu_op_e   op,
    input  alu_pkg::alu_word_t a,
    input  alu_pkg::alu_word_t b,
    input  alu_pkg::alu_word_t addsub_result,
    output alu_pkg::alu_word_t result
);

    alu_pkg::alu_word_t result_d;

    // Logic opcodes are decoded here only, anything else takes the adder path
    always_comb begin
        case (op)
            alu_pkg::op_and: begin
                result_d = a & b;
            end
            alu_pkg::op_or: begin
                result_d = a | b;
            end
            alu_pkg::op_xor: begin
                result_d = a ^ b;
            end
            default: begin
                result_d = addsub_result;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            result <= '0;
        end else begin
            result <= result_d;
        end
    end

endmodule

// File: hw/delay_line.sv
`timescale 1ns/1ps

module delay_line #(
    parameter int DEPTH = 1,
    parameter int WIDTH = 1
) (
    input  logic             clock,
    input  logic             rst,
    input  logic [WIDTH-1:0] din,
    output logic [WIDTH-1:0] dout
);

    // Stage 0 is written from din, the last stage drives dout
    logic [WIDTH-1:0] stages [DEPTH];

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                stages[i] <= '0;
            end
        end else begin
            stages[0] <= din;
            for (int i = 1; i < DEPTH; i++) begin
                stages[i] <= stages[i-1];
            end
        end
    end

    assign dout = stages[DEPTH-1];

endmodule

// File: hw/mult_unit.sv
`timescale 1ns/1ps

module mult_unit #(
    parameter int STAGES = 3
) (
    input  logic               clock,
    input  logic               rst,
    input  logic               is_signed,
    input  alu_pkg::alu_word_t a,
    input  alu_pkg::alu_word_t b,
    output alu_pkg::alu_word_t product_lo,
    output alu_pkg::alu_word_t product_hi
);

    localparam int W = $bits(alu_pkg::alu_word_t);

    // One extra bit so signed and unsigned share a single signed multiplier
    logic signed [W:0]     a_ext;
    logic signed [W:0]     b_ext;
    logic signed [W:0]     a_q;
    logic signed [W:0]     b_q;
    logic signed [2*W+1:0] full;

    // Product retiming registers, the first one catches the multiplier output
    alu_pkg::alu_dword_t   prod_q [STAGES-1];

    always_comb begin
        a_ext = is_signed ? {a[W-1], a} : {1'b0, a};
        b_ext = is_signed ? {b[W-1], b} : {1'b0, b};
        full  = a_q * b_q;
    end

    // Stage 1 holds the extended operands
    always_ff @(posedge clock) begin
        if (rst) begin
            a_q <= '0;
            b_q <= '0;
        end else begin
            a_q <= a_ext;
            b_q <= b_ext;
        end
    end

    // Remaining stages carry the product, one operation per slot
    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < STAGES - 1; i++) begin
                prod_q[i] <= '0;
            end
        end else begin
            prod_q[0] <= full[2*W-1:0];
            for (int i = 1; i < STAGES - 1; i++) begin
                prod_q[i] <= prod_q[i-1];
            end
        end
    end

    assign product_lo = prod_q[STAGES-2][W-1:0];
    assign product_hi = prod_q[STAGES-2][2*W-1:W];

endmodule

// File: tb/alu_core_tb.sv
`timescale 1ns/1ps
`include "alu_defs.svh"

module alu_core_tb #(
    parameter logic [31:0] SEED = 32'he328b0a9
);

    localparam int W            = `ALU_WORD_WIDTH;
    localparam int LAT          = `ALU_LATENCY;
    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 3;
    localparam int IDLE_CYCLES  = LAT + 2;
    localparam int NUM_REQUESTS = 2000;
    localparam int NUM_OPS      = 10;
    // Whole run in cycles with some margin
    localparam int TOTAL_CYCLES = RESET_CYCLES + IDLE_CYCLES + NUM_REQUESTS + LAT + 20;

    logic              clock;
    logic              rst;
    alu_pkg::alu_req_t req;
    alu_pkg::alu_tag_t tag_in;
    alu_pkg::alu_rsp_t rsp;

    integer            seed;
    int                checked;
    alu_pkg::alu_rsp_t expected_q [$];

    alu_core uut (
        .clock  (clock),
        .rst    (rst),
        .req    (req),
        .tag_in (tag_in),
        .rsp    (rsp)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string field, input int index,
                                   input logic [31:0] expected, input logic [31:0] actual);
        stop_with_failure($sformatf("ERROR: %0d ns: request %0d, %s expected 0x%0h, got 0x%0h",
                                    $time, index, field, expected, actual));
    endtask

    // Expected response worked out from the ALU rules, independent of the DUT
    function automatic alu_pkg::alu_rsp_t model_response(input alu_pkg::alu_req_t r,
                                                         input alu_pkg::alu_tag_t t);
        alu_pkg::alu_rsp_t     e;
        logic [W:0]            wide;
        logic [2*W-1:0]        ua;
        logic [2*W-1:0]        ub;
        logic [2*W-1:0]        uprod;
        logic signed [2*W-1:0] sa;
        logic signed [2*W-1:0] sb;
        logic signed [2*W-1:0] sprod;
        e     = '0;
        e.op  = r.op;
        e.tag = t;
        ua    = {{W{1'b0}}, r.a};
        ub    = {{W{1'b0}}, r.b};
        uprod = ua * ub;
        sa    = {{W{r.a[W-1]}}, r.a};
        sb    = {{W{r.b[W-1]}}, r.b};
        sprod = sa * sb;
        case (r.op)
            alu_pkg::op_add: begin
                wide        = {1'b0, r.a} + {1'b0, r.b} + {{W{1'b0}}, r.carry_in};
                e.result    = wide[W-1:0];
                e.carry_out = wide[W];
            end
            alu_pkg::op_sub: begin
                wide        = {1'b0, r.a} + {1'b0, ~r.b} + {{W{1'b0}}, r.carry_in};
                e.result    = wide[W-1:0];
                e.carry_out = wide[W];
            end
            alu_pkg::op_and:     e.result = r.a & r.b;
            alu_pkg::op_or:      e.result = r.a | r.b;
            alu_pkg::op_xor:     e.result = r.a ^ r.b;
            alu_pkg::op_mulu_lo: e.result = uprod[W-1:0];
            alu_pkg::op_mulu_hi: e.result = uprod[2*W-1:W];
            alu_pkg::op_muls_lo: e.result = sprod[W-1:0];
            alu_pkg::op_muls_hi: e.result = sprod[2*W-1:W];
            default:             e.result = '0;
        endcase
        return e;
    endfunction

    task automatic check_response(input alu_pkg::alu_rsp_t exp, input int index);
        assert (rsp.op == exp.op)
        else report_mismatch("op", index, 32'(exp.op), 32'(rsp.op));
        assert (rsp.tag == exp.tag)
        else report_mismatch("tag", index, 32'(exp.tag), 32'(rsp.tag));
        // A nop carries no defined result
        if (exp.op != alu_pkg::op_nop) begin
            assert (rsp.result == exp.result)
            else report_mismatch("result", index, 32'(exp.result), 32'(rsp.result));
        end
        if (exp.op == alu_pkg::op_add || exp.op == alu_pkg::op_sub) begin
            assert (rsp.carry_out == exp.carry_out)
            else report_mismatch("carry_out", index, 32'(exp.carry_out), 32'(rsp.carry_out));
        end
        checked++;
    endtask

    task automatic drive_random_request();
        logic [31:0]       op_idx;
        logic [31:0]       rnd;
        alu_pkg::alu_req_t r;
        alu_pkg::alu_tag_t t;
        op_idx     = $unsigned($random(seed)) % NUM_OPS;
        r.op       = alu_pkg::alu_op_e'(op_idx[`ALU_OP_WIDTH-1:0]);
        rnd        = $random(seed);
        r.a        = rnd[W-1:0];
        rnd        = $random(seed);
        r.b        = rnd[W-1:0];
        rnd        = $random(seed);
        r.carry_in = rnd[0];
        t          = rnd[`ALU_TAG_WIDTH:1];
        req        = r;
        tag_in     = t;
        expected_q.push_back(model_response(r, t));
    endtask

    initial begin
        alu_pkg::alu_rsp_t exp;
        int                popped;
        seed    = SEED;
        checked = 0;
        popped  = 0;
        rst     = 1'b1;
        req     = '0;
        tag_in  = '0;
        repeat (RESET_CYCLES) @(posedge clock);
        #2 rst = 1'b0;

        // Idle pipeline must show a clean nop response
        repeat (IDLE_CYCLES) begin
            @(posedge clock);
            #1;
            assert (rsp == '0)
            else report_mismatch("idle response", -1, 32'h0, 32'(rsp));
        end

        // Request c enters after edge c and shows up after edge c+LAT
        for (int c = 0; c < NUM_REQUESTS + LAT; c++) begin
            @(posedge clock);
            #1;
            if (c >= LAT) begin
                exp = expected_q.pop_front();
                check_response(exp, popped);
                popped++;
            end
            #1;
            if (c < NUM_REQUESTS) begin
                drive_random_request();
            end else begin
                req    = '0;
                tag_in = '0;
            end
        end

        if (expected_q.size() == 0) begin
            $display("Checked %0d responses", checked);
            $display("RESULT: PASS");
            $finish;
        end else begin
            stop_with_failure($sformatf("Expected-result queue still holds %0d entries",
                                        expected_q.size()));
        end
    end

    // Watchdog
    initial begin
        #(TOTAL_CYCLES * CLK_PERIOD);
        stop_with_failure("Timeout: the test did not finish within the expected time");
    end

endmodule
